// File: bench/ex_tests.mem
// test_unit_bch_func_ctl_opa_opb_rd_expdata_expbranch (unit 0 ALU 1 MUL, ctl 1 halt 2 kill)
// Hex fields joined by underscores, one instruction per line
01_0_0_0_0_00000005_00000007_01_0000000C_0
02_0_0_0_0_FFFFFFFF_00000001_02_00000000_0
03_0_0_1_0_00000003_00000005_03_FFFFFFFE_0
04_0_0_2_0_F0F0F0F0_FF00FF00_04_F000F000_0
05_0_0_3_0_F0F0F0F0_0F0F0000_05_FFFFF0F0_0
06_0_0_4_0_AAAA5555_FFFF0000_06_55555555_0
07_0_0_5_0_00000001_0000001F_07_80000000_0
08_0_0_6_0_80000000_00000024_08_08000000_0
09_0_0_7_0_80000000_00000004_09_F8000000_0
0A_0_0_8_0_FFFFFFFF_00000001_0A_00000001_0
0B_0_0_9_0_FFFFFFFF_00000001_0B_00000000_0
0C_0_1_A_0_12345678_12345678_00_00000001_1
0D_0_1_B_0_00000001_00000001_00_00000000_0
0E_0_1_C_0_80000000_00000000_00_00000001_1
0F_0_1_D_0_80000000_00000000_00_00000000_0
10_0_1_E_0_80000000_00000000_00_00000000_0
11_0_1_F_0_80000000_00000000_00_00000001_1
12_1_0_0_0_00000007_FFFFFFFD_12_FFFFFFEB_0
13_1_0_1_1_80000000_00000002_13_FFFFFFFF_0
14_1_0_2_0_FFFFFFFF_FFFFFFFF_14_FFFFFFFF_0
15_1_0_3_0_FFFFFFFF_FFFFFFFF_15_FFFFFFFE_0
16_1_0_0_2_00000003_00000004_16_0000000C_0
17_0_0_0_0_00000064_00000001_17_00000065_0

// File: src.f
hdl/ex_pkg.sv
hdl/ex_op_if.sv
hdl/ex_issue.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
bench/tb_clock.sv
bench/tb_ex_stage.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing -f src.f --top-module tb_ex_stage -o tb_ex_stage
	./obj_dir/tb_ex_stage

clean:
	rm -rf obj_dir

// File: bench/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned MAX_VEC    = 64;
  localparam int unsigned VEC_W      = 132;
  localparam int unsigned HALT_LEN   = 3;

  logic clk;
  logic rst_n;
  logic instr_valid_i, alu_en_i, mul_en_i, bch_i, rf_we_i;
  logic [3:0] func_i;
  logic [XLEN-1:0] operand_a_i, operand_b_i;
  logic [REG_ADDR_W-1:0] rf_waddr_i;
  logic halt_i, kill_i, wb_ready_i;
  logic ex_ready_o, ex_valid_o, branch_decision_o;
  logic wb_valid_o, wb_rf_we_o, wb_bch_taken_o;
  logic [REG_ADDR_W-1:0] wb_rf_waddr_o;
  logic [XLEN-1:0] wb_rf_wdata_o;

  logic [VEC_W-1:0] vecs [0:MAX_VEC-1];
  int   num_vec;
  int   cycle_limit;
  int   cycles;
  int   pending [$];
  logic [15:0] lfsr;

  tb_clock #(.PERIOD(100), .RESET_CYCLES(16)) u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .instr_valid_i     (instr_valid_i),
    .alu_en_i          (alu_en_i),
    .mul_en_i          (mul_en_i),
    .bch_i             (bch_i),
    .rf_we_i           (rf_we_i),
    .func_i            (func_i),
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .rf_waddr_i        (rf_waddr_i),
    .halt_i            (halt_i),
    .kill_i            (kill_i),
    .wb_ready_i        (wb_ready_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_bch_taken_o    (wb_bch_taken_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o)
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Galois step, taps for a maximal 16-bit sequence
  function automatic logic [15:0] lfsr_step(input logic [15:0] x);
    return x[0] ? ((x >> 1) ^ 16'hB400) : (x >> 1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1, "run aborted");
  endtask

  // One vector held until the stage accepts it
  task automatic present_vector(input int idx);
    logic [VEC_W-1:0] v;
    int   tnum;
    logic [3:0] ctl;
    logic exp_br;
    logic accepted;
    v        = vecs[idx];
    tnum     = int'(v[131:124]);
    ctl      = v[111:108];
    exp_br   = v[0];
    alu_en_i = (v[123:120] == 4'd0);
    mul_en_i = (v[123:120] == 4'd1);
    bch_i    = v[116];
    rf_we_i  = !v[116];
    func_i   = v[115:112];
    operand_a_i   = v[107:76];
    operand_b_i   = v[75:44];
    rf_waddr_i    = v[40:36];
    instr_valid_i = 1'b1;
    // Halt after one cycle, multiplier holds its captured product
    if (ctl == 4'd1) begin
      @(posedge clk);
      #10 halt_i = 1'b1;
      repeat (HALT_LEN) begin
        @(negedge clk);
        check_value($sformatf("test %0d ex_ready_o in halt", tnum), 32'd0, {31'd0, ex_ready_o});
        check_value($sformatf("test %0d ex_valid_o in halt", tnum), 32'd0, {31'd0, ex_valid_o});
        @(posedge clk);
        #10;
      end
      halt_i = 1'b0;
    end
    // Kill one cycle into the multiply
    if (ctl == 4'd2) begin
      @(posedge clk);
      #10 kill_i = 1'b1;
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      if (bch_i)
        check_value($sformatf("test %0d branch_decision_o", tnum),
                    {31'd0, exp_br}, {31'd0, branch_decision_o});
      accepted = ex_ready_o;
      @(posedge clk);
      #10;
    end
    kill_i = 1'b0;
    if (ctl != 4'd2) pending.push_back(idx);
  endtask

  ////////////////////
  // Back-pressure
  ////////////////////

  // One LFSR bit per cycle once reset is released
  initial begin
    wb_ready_i = 1'b1;
    lfsr       = 16'd59052;
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #10;
      wb_ready_i = lfsr[0];
      lfsr       = lfsr_step(lfsr);
    end
  end

  ////////////////////
  // Write-back monitor
  ////////////////////

  always @(negedge clk) begin
    logic [VEC_W-1:0] v;
    int tnum;
    if (!rst_n) begin
      check_value("reset wb_valid_o", 32'd0, {31'd0, wb_valid_o});
      check_value("reset wb_rf_we_o", 32'd0, {31'd0, wb_rf_we_o});
      check_value("reset wb_bch_taken_o", 32'd0, {31'd0, wb_bch_taken_o});
    end else if (wb_valid_o && wb_ready_i) begin
      assert (pending.size() != 0)
        else fail_run("A write-back arrived with no instruction outstanding");
      v    = vecs[pending.pop_front()];
      tnum = int'(v[131:124]);
      check_value($sformatf("test %0d wb_rf_we_o", tnum), {31'd0, !v[116]}, {31'd0, wb_rf_we_o});
      check_value($sformatf("test %0d wb_rf_waddr_o", tnum), {27'd0, v[40:36]},
                  {27'd0, wb_rf_waddr_o});
      if (!v[116])
        check_value($sformatf("test %0d wb_rf_wdata_o", tnum), v[35:4], wb_rf_wdata_o);
      // Taken flag only ever set by a branch
      check_value($sformatf("test %0d wb_bch_taken_o", tnum), {31'd0, v[116] & v[0]},
                  {31'd0, wb_bch_taken_o});
    end
  end

  // Cycle limit scaled by the number of vectors
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles > cycle_limit)
        fail_run("Timeout: the tests did not complete within the cycle limit");
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    instr_valid_i = 1'b0;
    alu_en_i      = 1'b0;
    mul_en_i      = 1'b0;
    bch_i         = 1'b0;
    rf_we_i       = 1'b0;
    func_i        = '0;
    operand_a_i   = '0;
    operand_b_i   = '0;
    rf_waddr_i    = '0;
    halt_i        = 1'b0;
    kill_i        = 1'b0;
    cycle_limit   = 1000;
    foreach (vecs[i]) vecs[i] = '0;
    $readmemh("bench/ex_tests.mem", vecs);
    // Test numbers start at 1, a zero entry ends the list
    num_vec = 0;
    while (num_vec < MAX_VEC && vecs[num_vec][131:124] != 8'd0)
      num_vec++;
    assert (num_vec != 0) else fail_run("No test vectors were read from the file");
    cycle_limit = 16 + 8 * num_vec;
    @(posedge rst_n);
    @(posedge clk);
    #10;
    for (int i = 0; i < num_vec; i++) present_vector(i);
    instr_valid_i = 1'b0;
    // Drain the outstanding write-backs
    while (pending.size() != 0) @(negedge clk);
    @(negedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD       = 100,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock, low first half
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset released a little after an edge, away from the flops
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; #(
  parameter int unsigned XLEN       = 32,
  parameter int unsigned REG_ADDR_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  logic                  alu_en_i,
  input  logic                  mul_en_i,
  input  logic                  bch_i,
  input  logic                  rf_we_i,
  input  logic [FUNC_W-1:0]     func_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic                  halt_i,
  input  logic                  kill_i,
  input  logic                  wb_ready_i,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  output logic                  branch_decision_o,
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic                  wb_bch_taken_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o
);

  // Unit results and multiplier handshake
  logic [XLEN-1:0] alu_result;
  logic            cmp_result;
  logic [XLEN-1:0] mul_result;
  logic            mul_valid;
  logic            mul_ready;

  ex_op_if #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) op_if ();

  ////////////////////
  // Issue
  ////////////////////

  ex_issue #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_issue (
    .instr_valid_i (instr_valid_i),
    .alu_en_i      (alu_en_i),
    .mul_en_i      (mul_en_i),
    .bch_i         (bch_i),
    .rf_we_i       (rf_we_i),
    .func_i        (func_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .rf_waddr_i    (rf_waddr_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .wb_ready_i    (wb_ready_i),
    .mul_ready_i   (mul_ready),
    .ex_ready_o    (ex_ready_o),
    .op            (op_if.issue)
  );

  ////////////////////
  // Functional units
  ////////////////////

  ex_alu #(.XLEN(XLEN)) u_alu (
    .op           (op_if.alu),
    .result_o     (alu_result),
    .cmp_result_o (cmp_result)
  );

  ex_mult #(.XLEN(XLEN)) u_mult (
    .clk      (clk),
    .rst_n    (rst_n),
    .halt_i   (halt_i),
    .kill_i   (kill_i),
    .ready_i  (wb_ready_i),
    .op       (op_if.mult),
    .result_o (mul_result),
    .valid_o  (mul_valid),
    .ready_o  (mul_ready)
  );

  ////////////////////
  // Write-back side
  ////////////////////

  ex_wb_reg #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_wb_reg (
    .clk               (clk),
    .rst_n             (rst_n),
    .wb_ready_i        (wb_ready_i),
    .op                (op_if.wb),
    .alu_result_i      (alu_result),
    .cmp_result_i      (cmp_result),
    .mul_result_i      (mul_result),
    .mul_valid_i       (mul_valid),
    .ex_valid_o        (ex_valid_o),
    .branch_decision_o (branch_decision_o),
    .wb_valid_o        (wb_valid_o),
    .wb_rf_we_o        (wb_rf_we_o),
    .wb_bch_taken_o    (wb_bch_taken_o),
    .wb_rf_waddr_o     (wb_rf_waddr_o),
    .wb_rf_wdata_o     (wb_rf_wdata_o)
  );

endmodule

`default_nettype wire

// File: hdl/ex_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_wb_reg #(
  parameter int unsigned XLEN       = 32,
  parameter int unsigned REG_ADDR_W = 5
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wb_ready_i,
  ex_op_if.wb                   op,
  input  logic [XLEN-1:0]       alu_result_i,
  input  logic                  cmp_result_i,
  input  logic [XLEN-1:0]       mul_result_i,
  input  logic                  mul_valid_i,
  output logic                  ex_valid_o,
  output logic                  branch_decision_o,
  output logic                  wb_valid_o,
  output logic                  wb_rf_we_o,
  output logic                  wb_bch_taken_o,
  output logic [REG_ADDR_W-1:0] wb_rf_waddr_o,
  output logic [XLEN-1:0]       wb_rf_wdata_o
);

  logic [XLEN-1:0] rf_wdata;
  logic            load;

  ////////////////////
  // Result select
  ////////////////////

  assign rf_wdata = op.mul_en ? mul_result_i : alu_result_i;

  // ALU is single cycle, multiply waits for its done flag
  assign ex_valid_o = op.issue_valid && (op.alu_en || (op.mul_en && mul_valid_i));

  // Straight from the compare of the present operands
  assign branch_decision_o = cmp_result_i;

  assign load = ex_valid_o && wb_ready_i;

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_o     <= 1'b0;
      wb_rf_we_o     <= 1'b0;
      wb_bch_taken_o <= 1'b0;
      wb_rf_waddr_o  <= '0;
      wb_rf_wdata_o  <= '0;
    end else if (load) begin
      wb_valid_o     <= 1'b1;
      wb_rf_we_o     <= op.rf_we;
      // Taken only for a real branch on the ALU
      wb_bch_taken_o <= op.bch && op.alu_en && cmp_result_i;
      wb_rf_waddr_o  <= op.rf_waddr;
      if (op.rf_we) wb_rf_wdata_o <= rf_wdata;
    end else if (wb_ready_i) begin
      // Downstream free but nothing valid here, insert a bubble
      wb_valid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ex_mult.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mult import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            halt_i,
  input  logic            kill_i,
  input  logic            ready_i,
  ex_op_if.mult           op,
  output logic [XLEN-1:0] result_o,
  output logic            valid_o,
  output logic            ready_o
);

  logic              signed_a;
  logic              signed_b;
  logic [2*XLEN-1:0] op_a_ext;
  logic [2*XLEN-1:0] op_b_ext;
  logic [2*XLEN-1:0] product;
  logic [XLEN-1:0]   result_d;
  logic [XLEN-1:0]   result_q;
  logic              valid_q;
  logic              capture;

  ////////////////////
  // Product
  ////////////////////

  // Signedness per operand; MULHU and MUL are treated unsigned
  always_comb begin
    signed_a = 1'b0;
    signed_b = 1'b0;
    unique case (op.func.mul.op)
      MUL_MULH:   begin
        signed_a = 1'b1;
        signed_b = 1'b1;
      end
      MUL_MULHSU: signed_a = 1'b1;
      default:    ;
    endcase
  end

  assign op_a_ext = {{XLEN{signed_a & op.operand_a[XLEN-1]}}, op.operand_a};
  assign op_b_ext = {{XLEN{signed_b & op.operand_b[XLEN-1]}}, op.operand_b};
  // Low 2*XLEN bits of the extended product are exact for every mode
  assign product  = op_a_ext * op_b_ext;
  assign result_d = (op.func.mul.op == MUL_MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];

  ////////////////////
  // Busy/done state
  ////////////////////

  // Capture once per instruction, never while halted or killed
  assign capture = op.mul_start && !valid_q && !halt_i && !kill_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (kill_i) begin
      valid_q <= 1'b0;
    end else if (!halt_i) begin
      if (valid_q) begin
        // Result handed to EX/WB on this edge
        if (ready_i) valid_q <= 1'b0;
      end else if (op.mul_start) begin
        valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) result_q <= result_d;
  end

  assign result_o = result_q;
  assign valid_o  = valid_q;
  // Idle with nothing pending, or done and draining this cycle
  assign ready_o  = (!valid_q && !op.mul_start) || (valid_q && ready_i);

endmodule

`default_nettype wire

// File: hdl/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; #(
  parameter int unsigned XLEN = 32
) (
  ex_op_if.alu            op,
  output logic [XLEN-1:0] result_o,
  output logic            cmp_result_o
);

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  alu_op_e            operator;
  logic               sub_en;
  logic [XLEN-1:0]    adder_b;
  logic [XLEN:0]      adder_sum;
  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;
  logic               is_equal;

  assign operator = op.func.alu;
  assign shamt    = op.operand_b[SHAMT_W-1:0];

  ////////////////////
  // Shared adder
  ////////////////////

  // Only ADD adds; SUB and every compare use a - b
  assign sub_en    = (operator != ALU_ADD);
  assign adder_b   = sub_en ? ~op.operand_b : op.operand_b;
  assign adder_sum = {1'b0, op.operand_a} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub_en};

  // No carry out of a + ~b + 1 means a borrow, so a < b unsigned
  assign lt_unsigned = !adder_sum[XLEN];
  // Differing signs decide directly, else the sign of the difference
  assign lt_signed   = (op.operand_a[XLEN-1] != op.operand_b[XLEN-1]) ?
                       op.operand_a[XLEN-1] : adder_sum[XLEN-1];
  assign is_equal    = (op.operand_a == op.operand_b);

  ////////////////////
  // Compare
  ////////////////////

  always_comb begin
    cmp_result_o = 1'b0;
    unique case (operator)
      ALU_EQ:           cmp_result_o = is_equal;
      ALU_NE:           cmp_result_o = !is_equal;
      ALU_SLT, ALU_LT:  cmp_result_o = lt_signed;
      ALU_GE:           cmp_result_o = !lt_signed;
      ALU_SLTU, ALU_LTU: cmp_result_o = lt_unsigned;
      ALU_GEU:          cmp_result_o = !lt_unsigned;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////
  // Result
  ////////////////////

  always_comb begin
    // Compare ops return the compare bit zero-extended
    result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    unique case (operator)
      ALU_ADD, ALU_SUB: result_o = adder_sum[XLEN-1:0];
      ALU_AND:          result_o = op.operand_a & op.operand_b;
      ALU_OR:           result_o = op.operand_a | op.operand_b;
      ALU_XOR:          result_o = op.operand_a ^ op.operand_b;
      ALU_SLL:          result_o = op.operand_a << shamt;
      ALU_SRL:          result_o = op.operand_a >> shamt;
      ALU_SRA:          result_o = $unsigned($signed(op.operand_a) >>> shamt);
      default:          result_o = {{(XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/ex_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ex_issue import ex_pkg::*; #(
  parameter int unsigned XLEN       = 32,
  parameter int unsigned REG_ADDR_W = 5
) (
  input  logic                  instr_valid_i,
  input  logic                  alu_en_i,
  input  logic                  mul_en_i,
  input  logic                  bch_i,
  input  logic                  rf_we_i,
  input  logic [FUNC_W-1:0]     func_i,
  input  logic [XLEN-1:0]       operand_a_i,
  input  logic [XLEN-1:0]       operand_b_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  logic                  halt_i,
  input  logic                  kill_i,
  input  logic                  wb_ready_i,
  input  logic                  mul_ready_i,
  output logic                  ex_ready_o,
  ex_op_if.issue                op
);

  ////////////////////
  // Operation fields
  ////////////////////

  // Raw function bits become the two-view word
  assign op.func      = ex_func_u'(func_i);
  assign op.operand_a = operand_a_i;
  assign op.operand_b = operand_b_i;
  assign op.alu_en    = alu_en_i;
  assign op.mul_en    = mul_en_i;
  assign op.bch       = bch_i;
  assign op.rf_we     = rf_we_i;
  assign op.rf_waddr  = rf_waddr_i;

  ////////////////////
  // Qualification
  ////////////////////

  // A halted or killed instruction never counts as valid downstream
  assign op.issue_valid = instr_valid_i && !halt_i && !kill_i;

  // Multiplier sees the raw valid
  // It holds its own state on halt and flushes on kill
  assign op.mul_start = instr_valid_i && mul_en_i;

  // Kill always drains the stage
  // Otherwise wait for multiplier and write-back, unless halted
  assign ex_ready_o = kill_i || (!halt_i && mul_ready_i && wb_ready_i);

endmodule

`default_nettype wire

// File: hdl/ex_op_if.sv
`timescale 1ns/1ps
`default_nettype none

// Qualified operation from issue to the units and the EX/WB register
interface ex_op_if import ex_pkg::*; #(
  parameter int unsigned XLEN       = 32,
  parameter int unsigned REG_ADDR_W = 5
);

  ex_func_u                func;
  logic [XLEN-1:0]         operand_a;
  logic [XLEN-1:0]         operand_b;
  logic                    alu_en;
  logic                    mul_en;
  logic                    bch;
  logic                    rf_we;
  logic [REG_ADDR_W-1:0]   rf_waddr;
  // Valid with halt and kill applied
  logic                    issue_valid;
  // Valid multiply, blind to halt and kill
  logic                    mul_start;

  modport issue (
    output func, operand_a, operand_b, alu_en, mul_en, bch,
    output rf_we, rf_waddr, issue_valid, mul_start
  );
  modport alu  (input func, operand_a, operand_b);
  modport mult (input func, operand_a, operand_b, mul_start);
  modport wb   (input alu_en, mul_en, bch, rf_we, rf_waddr, issue_valid);

endinterface

`default_nettype wire

// File: hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

  // Width of the function word shared by ALU and multiplier
  localparam int unsigned FUNC_W = 4;

  ////////////////////
  // ALU operators
  ////////////////////

  // Arithmetic, logic and shifts first
  // Compares in the upper half, branch compares last
  typedef enum logic [FUNC_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'hA,
    ALU_NE   = 4'hB,
    ALU_LT   = 4'hC,
    ALU_GE   = 4'hD,
    ALU_LTU  = 4'hE,
    ALU_GEU  = 4'hF
  } alu_op_e;

  ////////////////////
  // Multiplier operators
  ////////////////////

  // MUL keeps the low half, the others keep the high half
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  // One function word, read through the view of the enabled unit
  typedef union packed {
    alu_op_e alu;
    struct packed {
      logic [1:0] rsvd;
      mul_op_e    op;
    } mul;
  } ex_func_u;

endpackage

`default_nettype wire
